// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = chipRegisterBridgeTb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: list.f
logic/amigaBusPkg.sv
logic/colorClockPkg.sv
logic/colorClockSync.sv
logic/waitStateTimer.sv
logic/registerCycleFsm.sv
logic/busDataPath.sv
logic/chipRegisterBridge.sv
test/colorClockGen.sv
test/chipRegisterBridgeTb.sv

// File: logic/amigaBusPkg.sv
package amigaBusPkg;

    ////////////////////////////////////////////////////////////////////
    // CPU side of the register bridge
    ////////////////////////////////////////////////////////////////////

    // SIZ1:SIZ0 as driven by the 68040
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } sizeCode;

    // Held stable by the CPU from nRegSpace low until termination
    typedef struct packed {
        logic        rnw;
        sizeCode     size;
        // Word address, bit 0 picks the byte lane
        logic [7:0]  addr;
        logic [15:0] wrData;
    } cpuRequest;

    // Termination and read data back to the CPU
    typedef struct packed {
        logic        regTa;
        logic        busErr;
        logic [15:0] rdData;
    } cpuResponse;

    ////////////////////////////////////////////////////////////////////
    // Chip side, MC68000 style bus
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // Strobes are active low
        logic        nAs;
        logic        nLds;
        logic        nUds;
        logic        nRegEn;
        logic        rnw;
        logic [7:0]  addr;
        logic [15:0] wrData;
        // Drive enable for wrData
        logic        dataOe;
    } chipBusOut;

endpackage

// File: logic/busDataPath.sv
module busDataPath (
    input  logic                      CLK40,
    input  logic                      nRESET,
    input  logic                      nRegSpace,
    input  colorClockPkg::busState    state,
    input  logic                      asEn,
    input  logic                      dsEn,
    input  logic                      regEn,
    input  amigaBusPkg::cpuRequest    request,
    input  logic               [15:0] chipDataIn,
    output amigaBusPkg::chipBusOut    chipBus,
    output logic               [15:0] rdData
);

    import amigaBusPkg::*;
    import colorClockPkg::*;

    // Request as seen when the cycle opened
    cpuRequest cycleReq;

    // Byte lanes wanted by this cycle
    logic upperLane;
    logic lowerLane;

    // Follow the request while idle, last sample is the opening edge
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cycleReq <= '{rnw: 1'b1, size: sizeLong, addr: '0, wrData: '0};
        end else if (state == stateIdle && !nRegSpace) begin
            cycleReq <= request;
        end
    end

    // Reads take both lanes
    // Writes pick the lane from addr bit 0, word and long add the lower lane
    assign upperLane = cycleReq.rnw || !cycleReq.addr[0];
    assign lowerLane = cycleReq.rnw || cycleReq.addr[0] ||
                       (cycleReq.size == sizeWord) || (cycleReq.size == sizeLong);

    // Keep sampling through state 5, the final sample meets regTa
    always_ff @(posedge CLK40) begin
        if (state == stateLatch && cycleReq.rnw) begin
            rdData <= chipDataIn;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Chip bus outputs
    ////////////////////////////////////////////////////////////////////

    assign chipBus.nAs    = !asEn;
    assign chipBus.nUds   = !(dsEn && upperLane);
    assign chipBus.nLds   = !(dsEn && lowerLane);
    assign chipBus.nRegEn = !regEn;
    assign chipBus.rnw    = cycleReq.rnw;
    assign chipBus.addr   = cycleReq.addr;
    assign chipBus.wrData = cycleReq.wrData;
    // Only writes turn the data bus around
    assign chipBus.dataOe = dsEn && !cycleReq.rnw;

endmodule

// File: logic/chipRegisterBridge.sv
module chipRegisterBridge (
    input  logic                      CLK40,
    input  logic                      nRESET,
    input  logic                      c1,
    input  logic                      c3,
    input  logic                      nRegSpace,
    input  amigaBusPkg::cpuRequest    request,
    input  logic                      nDbr,
    input  logic                      casAgnus,
    input  logic               [15:0] chipDataIn,
    output amigaBusPkg::cpuResponse   response,
    output amigaBusPkg::chipBusOut    chipBus,
    output logic                      regCycle
);

    import colorClockPkg::*;

    // Color clock timing
    colorPhase phase;
    logic      phaseStart;

    // FSM to timer
    logic waiting;
    logic timeout;

    // FSM to data path
    busState     state;
    logic        asEn;
    logic        dsEn;
    logic        regEn;

    // Response pieces
    logic        regTa;
    logic        busErr;
    logic [15:0] rdData;

    colorClockSync colorClockSync0 (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .c1         (c1),
        .c3         (c3),
        .phase      (phase),
        .phaseStart (phaseStart)
    );

    waitStateTimer waitStateTimer0 (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .waiting    (waiting),
        .phaseStart (phaseStart),
        .timeout    (timeout)
    );

    registerCycleFsm registerCycleFsm0 (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .nRegSpace (nRegSpace),
        .rnw       (request.rnw),
        .phase     (phase),
        .nDbr      (nDbr),
        .casAgnus  (casAgnus),
        .timeout   (timeout),
        .state     (state),
        .asEn      (asEn),
        .dsEn      (dsEn),
        .regEn     (regEn),
        .regCycle  (regCycle),
        .waiting   (waiting),
        .regTa     (regTa),
        .busErr    (busErr)
    );

    busDataPath busDataPath0 (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .nRegSpace  (nRegSpace),
        .state      (state),
        .asEn       (asEn),
        .dsEn       (dsEn),
        .regEn      (regEn),
        .request    (request),
        .chipDataIn (chipDataIn),
        .chipBus    (chipBus),
        .rdData     (rdData)
    );

    // Termination from the FSM, data from the data path
    assign response = '{regTa: regTa, busErr: busErr, rdData: rdData};

endmodule

// File: logic/colorClockPkg.sv
package colorClockPkg;

    ////////////////////////////////////////////////////////////////////
    // Color clock phases and bus cycle states
    ////////////////////////////////////////////////////////////////////

    // Encoded as {C1, C3}
    // Sequence in time is LowLow, HighLow, HighHigh, LowHigh
    typedef enum logic [1:0] {
        phaseLowLow   = 2'b00,
        phaseHighLow  = 2'b10,
        phaseHighHigh = 2'b11,
        phaseLowHigh  = 2'b01
    } colorPhase;

    // MC68000 bus states used by a register cycle
    typedef enum logic [2:0] {
        stateIdle  = 3'd0,  // state 2
        stateWait  = 3'd1,  // state 4, wait states live here
        stateLatch = 3'd2,  // state 5
        stateHold  = 3'd3,  // state 6
        stateEnd   = 3'd4   // state 7
    } busState;

    // Flops in each C1/C3 synchronizer
    localparam int syncStages = 2;

    // Color clock periods allowed in stateWait
    localparam int maxWaitPeriods = 8;

    // Must hold maxWaitPeriods
    localparam int waitCountWidth = 4;

endpackage

// File: logic/colorClockSync.sv
module colorClockSync (
    input  logic                   CLK40,
    input  logic                   nRESET,
    input  logic                   c1,
    input  logic                   c3,
    output colorClockPkg::colorPhase phase,
    output logic                   phaseStart
);

    import colorClockPkg::*;

    // Synchronizer chains, oldest sample at the top bit
    logic [syncStages-1:0] c1Sync;
    logic [syncStages-1:0] c3Sync;

    // Phase seen on the previous clock
    colorPhase lastPhase;

    // Both chains come out of reset high
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Sync <= '1;
            c3Sync <= '1;
        end else begin
            c1Sync <= {c1Sync[syncStages-2:0], c1};
            c3Sync <= {c3Sync[syncStages-2:0], c3};
        end
    end

    // Name the synchronized pair
    assign phase = colorPhase'({c1Sync[syncStages-1], c3Sync[syncStages-1]});

    // Matches the synchronizer reset value
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            lastPhase <= phaseHighHigh;
        end else begin
            lastPhase <= phase;
        end
    end

    // One pulse per color clock period, on the first LowLow clock
    assign phaseStart = (phase == phaseLowLow) && (lastPhase != phaseLowLow);

endmodule

// File: logic/registerCycleFsm.sv
module registerCycleFsm (
    input  logic                     CLK40,
    input  logic                     nRESET,
    input  logic                     nRegSpace,
    input  logic                     rnw,
    input  colorClockPkg::colorPhase phase,
    input  logic                     nDbr,
    input  logic                     casAgnus,
    input  logic                     timeout,
    output colorClockPkg::busState   state,
    output logic                     asEn,
    output logic                     dsEn,
    output logic                     regEn,
    output logic                     regCycle,
    output logic                     waiting,
    output logic                     regTa,
    output logic                     busErr
);

    import colorClockPkg::*;

    // Direction taken when the cycle opened
    logic readCycle;

    // Agnus owns the chip bus while either is active
    logic agnusBusy;

    assign agnusBusy = !nDbr || casAgnus;

    // Timer runs only in state 4
    assign waiting = (state == stateWait);

    //////////////////////////////////////////////////////////////////////
    // MC68000 state sequence 2, 4, 5, 6, 7
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state     <= stateIdle;
            asEn      <= 1'b0;
            dsEn      <= 1'b0;
            regEn     <= 1'b0;
            regCycle  <= 1'b0;
            regTa     <= 1'b0;
            busErr    <= 1'b0;
            readCycle <= 1'b1;
        end else begin
            case (state)
                // State 2, cycles only open with C1 and C3 both low
                stateIdle: begin
                    regTa  <= 1'b0;
                    busErr <= 1'b0;
                    if (phase == phaseLowLow && !nRegSpace) begin
                        asEn      <= 1'b1;
                        regEn     <= 1'b1;
                        regCycle  <= 1'b1;
                        // Reads drive both strobes with nAs
                        dsEn      <= rnw;
                        readCycle <= rnw;
                        state     <= stateWait;
                    end
                end

                // State 4, stretched while Agnus holds the bus
                stateWait: begin
                    if (timeout) begin
                        // Give up, drop everything and flag a bus error
                        asEn     <= 1'b0;
                        dsEn     <= 1'b0;
                        regEn    <= 1'b0;
                        regCycle <= 1'b0;
                        busErr   <= 1'b1;
                        state    <= stateIdle;
                    end else if (phase == phaseHighHigh) begin
                        // Write strobes come on here
                        dsEn <= 1'b1;
                        if (!agnusBusy) begin
                            state <= stateLatch;
                        end
                    end
                end

                // State 5, read data is sampled here
                stateLatch: begin
                    if (phase == phaseLowHigh) begin
                        // early termination for reads only
                        regTa <= readCycle;
                        state <= stateHold;
                    end
                end

                // State 6
                stateHold: begin
                    regTa <= 1'b0;
                    if (phase == phaseLowLow) begin
                        state <= stateEnd;
                    end
                end

                // State 7, release on C1 rising
                stateEnd: begin
                    if (phase == phaseHighLow) begin
                        asEn     <= 1'b0;
                        dsEn     <= 1'b0;
                        regEn    <= 1'b0;
                        regCycle <= 1'b0;
                        // Writes terminate with the strobe release
                        regTa    <= !readCycle;
                        state    <= stateIdle;
                    end
                end

                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

endmodule

// File: logic/waitStateTimer.sv
module waitStateTimer (
    input  logic CLK40,
    input  logic nRESET,
    input  logic waiting,
    input  logic phaseStart,
    output logic timeout
);

    import colorClockPkg::*;

    // Color clock periods spent in stateWait so far
    logic [waitCountWidth-1:0] waitCount;
    logic                      limitReached;

    assign limitReached = (waitCount == waitCountWidth'(maxWaitPeriods));

    // Count period starts while the FSM is stalled
    // Stops at the limit, clears as soon as waiting drops
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            waitCount <= '0;
        end else if (!waiting) begin
            waitCount <= '0;
        end else if (phaseStart && !limitReached) begin
            waitCount <= waitCount + 1'b1;
        end
    end

    // Registered flag
    // Falls one clock after the FSM leaves stateWait
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            timeout <= 1'b0;
        end else begin
            timeout <= waiting && limitReached;
        end
    end

endmodule

// File: test/chipRegisterBridgeTb.sv
module chipRegisterBridgeTb;

    import amigaBusPkg::*;
    import colorClockPkg::*;

    localparam int numCycles = 60;
    // Clocks per color period
    localparam int periodClocks = 12;
    localparam int watchdogTime =
        (numCycles * ((maxWaitPeriods + 4) * periodClocks + 20) + 40) * 10;

    logic        CLK40;
    logic        nRESET;
    logic        c1;
    logic        c3;
    logic        nRegSpace;
    logic        nDbr;
    logic        casAgnus;
    logic        regCycle;
    logic [15:0] chipDataIn;
    cpuRequest   request;
    cpuResponse  response;
    chipBusOut   chipBus;

    // Reference model state
    logic [1:0]  c1Delay;
    logic [1:0]  c3Delay;
    colorPhase   tbPhase;
    colorPhase   prevPhase;
    cpuRequest   curReq;
    logic [15:0] expRd;
    logic [31:0] driverLfsr;
    logic [31:0] agnusLfsr;
    logic        freeHighHigh;
    // A HighHigh phase went by with nAs low, so write strobes are due
    logic        strobeDue;
    logic        prevRegTa;
    logic        prevBusErr;
    logic        agnusBusy;
    logic        lowerExp;
    int          waitPeriods;
    int          errors;
    int          reads;
    int          writes;
    int          busErrors;

    colorClockGen colorClockGen0 (.CLK40(CLK40), .nRESET(nRESET), .c1(c1), .c3(c3));

    chipRegisterBridge dut0 (
        .CLK40(CLK40), .nRESET(nRESET), .c1(c1), .c3(c3),
        .nRegSpace(nRegSpace), .request(request), .nDbr(nDbr),
        .casAgnus(casAgnus), .chipDataIn(chipDataIn),
        .response(response), .chipBus(chipBus), .regCycle(regCycle)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, inout logic [31:0] state, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsrStep(state);
            value = {value[30:0], state[0]};
        end
    endtask

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic reportRule(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Phase as the DUT sees it, two flops behind the pins
    always @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Delay <= '1;
            c3Delay <= '1;
        end else begin
            c1Delay <= {c1Delay[0], c1};
            c3Delay <= {c3Delay[0], c3};
        end
    end
    assign tbPhase   = colorPhase'({c1Delay[1], c3Delay[1]});
    assign agnusBusy = !nDbr || casAgnus;
    assign lowerExp  = curReq.addr[0] || (curReq.size == sizeWord) || (curReq.size == sizeLong);

    //////////////////////////////////////////////////////////////////////
    // Checks, sampled on the falling edge where outputs are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK40) begin
        // Held in reset
        if (!nRESET) begin
            assert (!regCycle) else reportValue("regCycle", 32'h0, 32'(regCycle));
        end
        // Idle bus
        if (nRegSpace && !regCycle) begin
            assert (chipBus.nAs && chipBus.nLds && chipBus.nUds && chipBus.nRegEn)
                else reportValue("idle strobes", 32'hf, 32'({chipBus.nAs, chipBus.nLds,
                                 chipBus.nUds, chipBus.nRegEn}));
            assert (!response.regTa && !response.busErr && !chipBus.dataOe)
                else reportValue("idle regTa busErr dataOe", 32'h0, 32'({response.regTa,
                                 response.busErr, chipBus.dataOe}));
        end
        // Write lanes and data
        if (chipBus.dataOe) begin
            assert (chipBus.nUds == curReq.addr[0])
                else reportValue("nUds", 32'(curReq.addr[0]), 32'(chipBus.nUds));
            assert (chipBus.nLds == !lowerExp)
                else reportValue("nLds", 32'(!lowerExp), 32'(chipBus.nLds));
            assert (chipBus.wrData == curReq.wrData)
                else reportValue("wrData", 32'(curReq.wrData), 32'(chipBus.wrData));
            assert (chipBus.addr == curReq.addr)
                else reportValue("addr", 32'(curReq.addr), 32'(chipBus.addr));
        end
        // Write strobes stay on from the first HighHigh until release
        if (!chipBus.nAs && strobeDue && !curReq.rnw) begin
            assert (chipBus.dataOe) else reportValue("dataOe", 32'h1, 32'(chipBus.dataOe));
        end
        // Direction follows the request for the whole cycle
        if (!chipBus.nAs) begin
            assert (chipBus.rnw == curReq.rnw)
                else reportValue("chipBus rnw", 32'(curReq.rnw), 32'(chipBus.rnw));
        end
        // Reads drive both lanes together with nAs
        if (!chipBus.nAs && curReq.rnw) begin
            assert (!chipBus.nUds && !chipBus.nLds)
                else reportValue("read strobes", 32'h0, 32'({chipBus.nUds, chipBus.nLds}));
            assert (!chipBus.dataOe) else reportValue("dataOe", 32'h0, 32'(chipBus.dataOe));
        end
        // Termination is a single clock
        assert (!(response.regTa && prevRegTa)) else reportRule("regTa longer than one cycle");
        assert (!(response.busErr && prevBusErr)) else reportRule("busErr longer than one cycle");
        if (response.regTa && curReq.rnw) begin
            assert (response.rdData == expRd)
                else reportValue("rdData", 32'(expRd), 32'(response.rdData));
        end
        if (response.regTa && !curReq.rnw) begin
            assert (freeHighHigh) else reportRule("write ended before a free HighHigh phase");
        end
        if (response.regTa) begin
            assert (waitPeriods < maxWaitPeriods)
                else reportRule("regTa where a timeout was due");
            // Reads end early, writes end with the release
            assert (regCycle == curReq.rnw)
                else reportValue("regCycle", 32'(curReq.rnw), 32'(regCycle));
        end
        // Stall while Agnus owns the bus
        if (!chipBus.nAs && !freeHighHigh && agnusBusy && waitPeriods < maxWaitPeriods) begin
            assert (!response.regTa && !response.busErr)
                else reportRule("cycle ended while Agnus held the bus");
            assert (!chipBus.nRegEn) else reportValue("nRegEn", 32'h0, 32'(chipBus.nRegEn));
            assert (regCycle) else reportValue("regCycle", 32'h1, 32'(regCycle));
        end
        if (response.busErr) begin
            assert (waitPeriods >= maxWaitPeriods && !freeHighHigh)
                else reportRule("busErr before the wait limit");
            assert (!regCycle) else reportValue("regCycle", 32'h0, 32'(regCycle));
        end
        // Strobes gone after a bus error
        if (prevBusErr) begin
            assert (chipBus.nAs && chipBus.nUds && chipBus.nLds)
                else reportValue("strobes after busErr", 32'h7, 32'({chipBus.nAs,
                                 chipBus.nUds, chipBus.nLds}));
        end

        // Model update for the next edge
        if (!chipBus.nAs && !freeHighHigh && tbPhase == phaseLowLow && prevPhase != phaseLowLow)
            waitPeriods++;
        if (!chipBus.nAs && tbPhase == phaseHighHigh && !agnusBusy)
            freeHighHigh = 1'b1;
        if (!chipBus.nAs && tbPhase == phaseHighHigh)
            strobeDue = 1'b1;
        if (chipBus.nAs && !response.regTa && !response.busErr) begin
            freeHighHigh = 1'b0;
            strobeDue    = 1'b0;
            waitPeriods  = 0;
        end
        prevPhase  = tbPhase;
        prevRegTa  = response.regTa;
        prevBusErr = response.busErr;
    end

    //////////////////////////////////////////////////////////////////////
    // Agnus model, random free gaps and bus holds
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] which;
        nDbr     = 1'b1;
        casAgnus = 1'b0;
        wait (nRESET);
        forever begin
            takeBits(6, agnusLfsr, v);
            repeat (int'(v[5:0]) + 1) @(posedge CLK40);
            takeBits(1, agnusLfsr, which);
            takeBits(4, agnusLfsr, v);
            @(posedge CLK40);
            if (which[0]) nDbr <= 1'b0;
            else casAgnus <= 1'b1;
            repeat (int'(v[3:0]) * periodClocks + 1) @(posedge CLK40);
            nDbr     <= 1'b1;
            casAgnus <= 1'b0;
        end
    end

    // Hang guard
    initial begin
        #(watchdogTime);
        $display("Run stopped by the watchdog, a bus cycle never terminated");
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // CPU side driver
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] v;
        logic [31:0] gap;
        nRegSpace    = 1'b1;
        request      = '0;
        chipDataIn   = '0;
        curReq       = '0;
        expRd        = '0;
        errors       = 0;
        reads        = 0;
        writes       = 0;
        busErrors    = 0;
        waitPeriods  = 0;
        freeHighHigh = 1'b0;
        strobeDue    = 1'b0;
        prevRegTa    = 1'b0;
        prevBusErr   = 1'b0;
        prevPhase    = phaseHighHigh;
        driverLfsr   = 32'h1e7c_3f10;
        takeBits(32, driverLfsr, agnusLfsr);
        wait (nRESET);
        repeat (2) @(posedge CLK40);
        for (int i = 0; i < numCycles; i++) begin
            takeBits(27, driverLfsr, v);
            takeBits(16, driverLfsr, gap);
            @(posedge CLK40);
            curReq     <= cpuRequest'(v[26:0]);
            request    <= cpuRequest'(v[26:0]);
            chipDataIn <= gap[15:0];
            expRd      <= gap[15:0];
            nRegSpace  <= 1'b0;
            do @(negedge CLK40); while (!response.regTa && !response.busErr);
            if (response.busErr) busErrors++;
            else if (curReq.rnw) reads++;
            else writes++;
            @(posedge CLK40);
            nRegSpace <= 1'b1;
            do @(negedge CLK40); while (regCycle);
            takeBits(4, driverLfsr, gap);
            repeat (int'(gap[3:0])) @(posedge CLK40);
        end
        repeat (4) @(posedge CLK40);
        $display("Errors: %0d over %0d cycles (%0d reads, %0d writes, %0d bus errors)",
                 errors, numCycles, reads, writes, busErrors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/colorClockGen.sv
module colorClockGen (
    output logic CLK40,
    output logic nRESET,
    output logic c1,
    output logic c3
);

    // Clock position inside one color clock period, 3 clocks per quarter
    int quarterCount;

    initial begin
        CLK40        = 1'b0;
        nRESET       = 1'b0;
        c1           = 1'b0;
        c3           = 1'b0;
        quarterCount = 0;
        forever #5 CLK40 = !CLK40;
    end

    // Reset held for 5 clocks
    initial begin
        repeat (5) @(posedge CLK40);
        nRESET <= 1'b1;
    end

    // Quadrature pair, C1 leads C3 by one quarter
    always @(posedge CLK40) begin
        quarterCount <= (quarterCount + 1) % 12;
        c1           <= (quarterCount / 3 == 0) || (quarterCount / 3 == 1);
        c3           <= (quarterCount / 3 == 1) || (quarterCount / 3 == 2);
    end

endmodule
